//--- include/rx_pcs_cfg.svh
// fixed sizes of the 64b/66b receive front end, included by every file that sizes a port or counter
`ifndef RX_PCS_CFG_SVH
`define RX_PCS_CFG_SVH

// block layout
`define RX_BLOCK_W       66
`define RX_PAYLOAD_W     64
`define RX_SH_W          2

// block lock
`define RX_LOCK_COUNT    64
`define RX_LOCK_WINDOW   1024

// bit error rate monitor
`define RX_BER_WINDOW    256
`define RX_BER_THRESHOLD 16

// register block
`define RX_SH_LIMIT_W    8
`define RX_COUNT_W       16
`define RX_WB_ADR_W      3
`define RX_WB_DAT_W      32

`endif

//--- src/rx_pcs_pkg.sv
// line coding constants of the 64b/66b receive path, imported by the sync and descrambler blocks

`include "rx_pcs_cfg.svh"

package rx_pcs_pkg;

    // the only two legal sync headers
    localparam logic [`RX_SH_W-1:0] SH_DATA = 2'b01;
    localparam logic [`RX_SH_W-1:0] SH_CTRL = 2'b10;

    // x^58 + x^39 + 1, delays in bits of the serial stream
    localparam int SCR_TAP_A = 39;
    localparam int SCR_TAP_B = 58;

endpackage

//--- src/rx_regs_pkg.sv
// register map of the receive front end, imported by the Wishbone register block

`include "rx_pcs_cfg.svh"

package rx_regs_pkg;

    // word addresses
    localparam logic [`RX_WB_ADR_W-1:0] REG_CTRL         = 3'd0;
    localparam logic [`RX_WB_ADR_W-1:0] REG_SH_LIMIT     = 3'd1;
    localparam logic [`RX_WB_ADR_W-1:0] REG_STATUS       = 3'd2;
    localparam logic [`RX_WB_ADR_W-1:0] REG_ERR_COUNT    = 3'd3;
    localparam logic [`RX_WB_ADR_W-1:0] REG_HI_BER_COUNT = 3'd4;

    // bit positions in CTRL and STATUS
    localparam int CTRL_ENABLE_BIT   = 0;
    localparam int CTRL_BYPASS_BIT   = 1;
    localparam int STATUS_LOCK_BIT   = 0;
    localparam int STATUS_HI_BER_BIT = 1;

    // enable on, bypass off
    localparam logic [`RX_WB_DAT_W-1:0]    CTRL_RESET     = 32'h0000_0001;
    localparam logic [`RX_SH_LIMIT_W-1:0] SH_LIMIT_RESET = 8'd16;

endpackage

//--- src/block_sync.sv
// sync header checker and block lock FSM, sees one header per valid block from the line
`timescale 1ns/1ps
`include "rx_pcs_cfg.svh"

module block_sync
    import rx_pcs_pkg::*;
(
    input  logic                      i_clock,
    input  logic                      i_reset,
    input  logic                      i_enable,
    input  logic                      i_valid,
    input  logic [`RX_SH_W-1:0]       i_sync_header,
    input  logic [`RX_SH_LIMIT_W-1:0] i_sh_limit,
    output logic                      o_block_lock,
    output logic                      o_sh_error
);

    localparam int GOOD_W = $clog2(`RX_LOCK_COUNT);
    localparam int WIN_W  = $clog2(`RX_LOCK_WINDOW);

    logic                      sh_valid;
    logic [GOOD_W-1:0]         good_count;
    logic [WIN_W-1:0]          win_count;
    logic [`RX_SH_LIMIT_W-1:0] inv_count;
    logic [`RX_SH_LIMIT_W-1:0] inv_next;

    assign sh_valid = (i_sync_header == SH_DATA) || (i_sync_header == SH_CTRL);
    assign inv_next = inv_count + 1'b1;

    always_ff @(posedge i_clock)
    begin
        if (i_reset || !i_enable)
        begin
            o_block_lock <= 1'b0;
            good_count   <= '0;
            win_count    <= '0;
            inv_count    <= '0;
        end
        else if (i_valid)
        begin
            if (!o_block_lock)
            begin
                // hunting, needs an unbroken run of good headers
                if (!sh_valid)
                begin
                    good_count <= '0;
                end
                else if (good_count == GOOD_W'(`RX_LOCK_COUNT - 1))
                begin
                    o_block_lock <= 1'b1;
                    good_count   <= '0;
                    win_count    <= '0;
                    inv_count    <= '0;
                end
                else
                begin
                    good_count <= good_count + 1'b1;
                end
            end
            else if (!sh_valid && (inv_next >= i_sh_limit))
            begin
                // too many bad headers in this window
                o_block_lock <= 1'b0;
                win_count    <= '0;
                inv_count    <= '0;
            end
            else if (win_count == WIN_W'(`RX_LOCK_WINDOW - 1))
            begin
                win_count <= '0;
                inv_count <= '0;
            end
            else
            begin
                win_count <= win_count + 1'b1;
                inv_count <= sh_valid ? inv_count : inv_next;
            end
        end
    end

    // one pulse per bad header, locked or not
    always_ff @(posedge i_clock)
    begin
        if (i_reset || !i_enable)
        begin
            o_sh_error <= 1'b0;
        end
        else
        begin
            o_sh_error <= i_valid && !sh_valid;
        end
    end

endmodule

//--- src/ber_monitor.sv
// high bit error rate detector, counts bad sync headers over fixed windows of valid blocks
`timescale 1ns/1ps
`include "rx_pcs_cfg.svh"

module ber_monitor
(
    input  logic i_clock,
    input  logic i_reset,
    input  logic i_block_lock,
    input  logic i_valid,
    input  logic i_sh_error,
    output logic o_hi_ber
);

    localparam int WIN_W = $clog2(`RX_BER_WINDOW);
    localparam int BER_W = $clog2(`RX_BER_THRESHOLD + 1);

    logic [WIN_W-1:0] win_count;
    logic [BER_W-1:0] ber_count;
    logic [BER_W-1:0] ber_next;
    logic             window_end;
    logic             hi_ber;

    // stops counting once the threshold is reached
    assign ber_next = (i_sh_error && (ber_count != BER_W'(`RX_BER_THRESHOLD))) ?
                      ber_count + 1'b1 : ber_count;
    assign window_end = i_valid && (win_count == WIN_W'(`RX_BER_WINDOW - 1));

    always_ff @(posedge i_clock)
    begin
        if (i_reset || !i_block_lock)
        begin
            win_count <= '0;
            ber_count <= '0;
            hi_ber    <= 1'b0;
        end
        else
        begin
            if (i_valid)
            begin
                win_count <= window_end ? '0 : win_count + 1'b1;
            end
            if (window_end)
            begin
                // a quiet window clears the flag
                ber_count <= '0;
                hi_ber    <= (ber_next == BER_W'(`RX_BER_THRESHOLD));
            end
            else
            begin
                ber_count <= ber_next;
                if (ber_next == BER_W'(`RX_BER_THRESHOLD))
                begin
                    hi_ber <= 1'b1;
                end
            end
        end
    end

    // flag goes down with lock in the same cycle
    assign o_hi_ber = hi_ber & i_block_lock;

endmodule

//--- src/descrambler.sv
// self-synchronizing x^58 + x^39 + 1 descrambler for the 64-bit payload, one cycle of latency
`timescale 1ns/1ps
`include "rx_pcs_cfg.svh"

module descrambler
    import rx_pcs_pkg::*;
(
    input  logic                   i_clock,
    input  logic                   i_reset,
    input  logic                   i_valid,
    input  logic                   i_bypass,
    input  logic [`RX_BLOCK_W-1:0] i_block,
    output logic                   o_valid,
    output logic [`RX_BLOCK_W-1:0] o_block
);

    localparam int PAY_W = `RX_PAYLOAD_W;

    // bit 0 of the payload is the first on the line, history[SCR_TAP_B-1] the newest
    logic [SCR_TAP_B-1:0]       history;
    logic [SCR_TAP_B+PAY_W-1:0] stream;
    logic [PAY_W-1:0]           payload;
    logic [PAY_W-1:0]           clear;

    assign payload = i_block[PAY_W-1:0];
    assign stream  = {payload, history};

    always_comb
    begin
        for (int i = 0; i < PAY_W; i++)
        begin
            clear[i] = stream[SCR_TAP_B + i] ^ stream[SCR_TAP_B - SCR_TAP_A + i] ^ stream[i];
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_valid <= 1'b0;
        end
        else
        begin
            o_valid <= i_valid;
        end
    end

    // history keeps running in bypass so leaving it is seamless
    always_ff @(posedge i_clock)
    begin
        if (i_valid)
        begin
            history <= stream[SCR_TAP_B+PAY_W-1:PAY_W];
            o_block <= {i_block[`RX_BLOCK_W-1:PAY_W], i_bypass ? payload : clear};
        end
    end

endmodule

//--- src/rx_status_regs.sv
// Wishbone classic slave with the receive controls, live status and clear-on-read counters
`timescale 1ns/1ps
`include "rx_pcs_cfg.svh"

module rx_status_regs
    import rx_regs_pkg::*;
(
    input  logic                      i_clock,
    input  logic                      i_reset,
    input  logic                      i_wb_cyc,
    input  logic                      i_wb_stb,
    input  logic                      i_wb_we,
    input  logic [`RX_WB_ADR_W-1:0]   i_wb_adr,
    input  logic [`RX_WB_DAT_W-1:0]   i_wb_dat,
    output logic [`RX_WB_DAT_W-1:0]   o_wb_dat,
    output logic                      o_wb_ack,
    input  logic                      i_block_lock,
    input  logic                      i_sh_error,
    input  logic                      i_hi_ber,
    output logic                      o_enable,
    output logic                      o_bypass,
    output logic [`RX_SH_LIMIT_W-1:0] o_sh_limit
);

    logic                    wb_req;
    logic                    wr_en;
    logic                    rd_en;
    logic                    err_clear;
    logic                    hi_ber_clear;
    logic                    hi_ber_d;
    logic                    hi_ber_rise;
    logic [`RX_COUNT_W-1:0]  err_count;
    logic [`RX_COUNT_W-1:0]  hi_ber_count;
    logic [`RX_WB_DAT_W-1:0] rd_word;

    // new transfer only while ack is low, so each one is acked once
    assign wb_req       = i_wb_cyc & i_wb_stb & ~o_wb_ack;
    assign wr_en        = wb_req & i_wb_we;
    assign rd_en        = wb_req & ~i_wb_we;
    assign err_clear    = rd_en && (i_wb_adr == REG_ERR_COUNT);
    assign hi_ber_clear = rd_en && (i_wb_adr == REG_HI_BER_COUNT);
    assign hi_ber_rise  = i_hi_ber & ~hi_ber_d;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_wb_ack   <= 1'b0;
            o_enable   <= CTRL_RESET[CTRL_ENABLE_BIT];
            o_bypass   <= CTRL_RESET[CTRL_BYPASS_BIT];
            o_sh_limit <= SH_LIMIT_RESET;
        end
        else
        begin
            o_wb_ack <= wb_req;
            if (wr_en)
            begin
                // read-only and unmapped words ignore writes
                case (i_wb_adr)
                    REG_CTRL:
                    begin
                        o_enable <= i_wb_dat[CTRL_ENABLE_BIT];
                        o_bypass <= i_wb_dat[CTRL_BYPASS_BIT];
                    end
                    REG_SH_LIMIT: o_sh_limit <= i_wb_dat[`RX_SH_LIMIT_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    // saturating counters, an event during the clearing read leaves 1
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            hi_ber_d     <= 1'b0;
            err_count    <= '0;
            hi_ber_count <= '0;
        end
        else
        begin
            hi_ber_d <= i_hi_ber;
            if (err_clear)
            begin
                err_count <= `RX_COUNT_W'(i_sh_error);
            end
            else if (i_sh_error && (err_count != '1))
            begin
                err_count <= err_count + 1'b1;
            end
            if (hi_ber_clear)
            begin
                hi_ber_count <= `RX_COUNT_W'(hi_ber_rise);
            end
            else if (hi_ber_rise && (hi_ber_count != '1))
            begin
                hi_ber_count <= hi_ber_count + 1'b1;
            end
        end
    end

    always_comb
    begin
        rd_word = '0;
        case (i_wb_adr)
            REG_CTRL:
            begin
                rd_word[CTRL_ENABLE_BIT] = o_enable;
                rd_word[CTRL_BYPASS_BIT] = o_bypass;
            end
            REG_SH_LIMIT:     rd_word[`RX_SH_LIMIT_W-1:0] = o_sh_limit;
            REG_STATUS:
            begin
                rd_word[STATUS_LOCK_BIT]   = i_block_lock;
                rd_word[STATUS_HI_BER_BIT] = i_hi_ber;
            end
            REG_ERR_COUNT:    rd_word[`RX_COUNT_W-1:0] = err_count;
            REG_HI_BER_COUNT: rd_word[`RX_COUNT_W-1:0] = hi_ber_count;
            default: ;
        endcase
    end

    // captured with the request, held while ack is high
    always_ff @(posedge i_clock)
    begin
        if (rd_en)
        begin
            o_wb_dat <= rd_word;
        end
    end

endmodule

//--- src/rx_pcs_top.sv
// receive front end top, block sync and BER monitor beside the descrambler, controlled over Wishbone
`timescale 1ns/1ps
`include "rx_pcs_cfg.svh"

module rx_pcs_top
(
    input  logic                    i_clock,
    input  logic                    i_reset,
    input  logic                    i_valid,
    input  logic [`RX_BLOCK_W-1:0]  i_block,
    input  logic                    i_wb_cyc,
    input  logic                    i_wb_stb,
    input  logic                    i_wb_we,
    input  logic [`RX_WB_ADR_W-1:0] i_wb_adr,
    input  logic [`RX_WB_DAT_W-1:0] i_wb_dat,
    output logic [`RX_WB_DAT_W-1:0] o_wb_dat,
    output logic                    o_wb_ack,
    output logic                    o_valid,
    output logic [`RX_BLOCK_W-1:0]  o_block,
    output logic                    o_block_lock,
    output logic                    o_hi_ber
);

    logic                      enable;
    logic                      bypass;
    logic [`RX_SH_LIMIT_W-1:0] sh_limit;
    logic                      sh_error;

    block_sync block_sync_i
    (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_enable      (enable),
        .i_valid       (i_valid),
        .i_sync_header (i_block[`RX_BLOCK_W-1 -: `RX_SH_W]),
        .i_sh_limit    (sh_limit),
        .o_block_lock  (o_block_lock),
        .o_sh_error    (sh_error)
    );

    ber_monitor ber_monitor_i
    (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_block_lock (o_block_lock),
        .i_valid      (i_valid),
        .i_sh_error   (sh_error),
        .o_hi_ber     (o_hi_ber)
    );

    descrambler descrambler_i
    (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_valid  (i_valid),
        .i_bypass (bypass),
        .i_block  (i_block),
        .o_valid  (o_valid),
        .o_block  (o_block)
    );

    rx_status_regs rx_status_regs_i
    (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_wb_cyc     (i_wb_cyc),
        .i_wb_stb     (i_wb_stb),
        .i_wb_we      (i_wb_we),
        .i_wb_adr     (i_wb_adr),
        .i_wb_dat     (i_wb_dat),
        .o_wb_dat     (o_wb_dat),
        .o_wb_ack     (o_wb_ack),
        .i_block_lock (o_block_lock),
        .i_sh_error   (sh_error),
        .i_hi_ber     (o_hi_ber),
        .o_enable     (enable),
        .o_bypass     (bypass),
        .o_sh_limit   (sh_limit)
    );

endmodule

//--- bench/rx_pcs_sva.sv
// concurrent checks on the register handshake, the status flags and the valid delay, bound to the receive top
`timescale 1ns/1ps

module rx_pcs_sva
(
    input logic i_clock,
    input logic i_reset,
    input logic i_wb_cyc,
    input logic i_wb_stb,
    input logic o_wb_ack,
    input logic i_valid,
    input logic o_valid,
    input logic o_block_lock,
    input logic o_hi_ber
);

    // ack answers a request and lasts a single cycle
    ack_follows_req: assert property (@(posedge i_clock) disable iff (i_reset)
        o_wb_ack |-> ($past(i_wb_cyc && i_wb_stb) && !$past(o_wb_ack)))
        else $error("ack without a preceding request");
    ack_one_cycle: assert property (@(posedge i_clock) disable iff (i_reset)
        o_wb_ack |=> !o_wb_ack)
        else $error("ack held for more than one cycle");
    // hi_ber only comes from a window that already ran under lock
    hi_ber_needs_lock: assert property (@(posedge i_clock) disable iff (i_reset)
        o_hi_ber |-> $past(o_block_lock))
        else $error("hi_ber set without block lock held in the cycle before");
    valid_delay: assert property (@(posedge i_clock)
        !i_reset |=> (o_valid == $past(i_valid)))
        else $error("o_valid is not i_valid delayed by one cycle");

endmodule

bind rx_pcs_top rx_pcs_sva rx_pcs_sva_i (.*);

//--- bench/rx_pcs_tb.sv
// testbench for the receive front end, random blocks from a scrambler checked against a cycle model
`timescale 1ns/1ps
`include "rx_pcs_cfg.svh"

module rx_pcs_tb;

    localparam int CYCLE_LIMIT = 6000;

    logic                    i_clock = 1'b0;
    logic                    i_reset;
    logic                    i_valid;
    logic [`RX_BLOCK_W-1:0]  i_block;
    logic                    i_wb_cyc;
    logic                    i_wb_stb;
    logic                    i_wb_we;
    logic [`RX_WB_ADR_W-1:0] i_wb_adr;
    logic [`RX_WB_DAT_W-1:0] i_wb_dat;
    logic [`RX_WB_DAT_W-1:0] o_wb_dat;
    logic                    o_wb_ack;
    logic                    o_valid;
    logic [`RX_BLOCK_W-1:0]  o_block;
    logic                    o_block_lock;
    logic                    o_hi_ber;

    logic [31:0] rng_state = 32'h1914_b8b7;
    logic [57:0] tx_hist = '0;
    logic [63:0] cur_plain;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    // reference model state
    logic        m_lock, m_sh_err, m_bh, m_hb_d, m_en, m_bypass, m_ack;
    logic        m_valid, m_exp_ok;
    int          m_good, m_win, m_inv, m_bw, m_bc, m_limit, m_err_cnt, m_hb_cnt, m_blocks;
    logic [31:0] m_rdata;
    logic [65:0] m_exp;

    rx_pcs_top rx_pcs_top_i (.*);

    always #20 i_clock = ~i_clock;

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // serial x^58 + x^39 + 1 scrambler, bit 0 goes first
    function automatic logic [63:0] scramble(input logic [63:0] plain);
        logic [63:0] s;
        for (int k = 0; k < 64; k++)
        begin
            s[k] = plain[k] ^ tx_hist[38] ^ tx_hist[57];
            tx_hist = {tx_hist[56:0], s[k]};
        end
        return s;
    endfunction

    task automatic check_value(input string name, input logic [65:0] got,
                               input logic [65:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond)
        else
        begin
            errors++;
            $display("error: %s", what);
        end
    endtask

    // exactly nbad corrupted headers at random places among n valid blocks
    task automatic run_blocks(input int n, input int nbad);
        int          sent;
        int          left_bad;
        logic        bad;
        logic [1:0]  hdr;
        logic [63:0] plain;
        sent     = 0;
        left_bad = nbad;
        while (sent < n)
        begin
            @(posedge i_clock);
            if (lcg_next() % 32'd4 == 32'd0)
            begin
                i_valid <= 1'b0;
            end
            else
            begin
                bad = (lcg_next() % 32'(n - sent)) < 32'(left_bad);
                if (bad)
                    left_bad--;
                hdr   = bad ? (lcg_next() & 1 ? 2'b00 : 2'b11) : (lcg_next() & 1 ? 2'b01 : 2'b10);
                plain = {lcg_next(), lcg_next()};
                cur_plain <= plain;
                i_block   <= {hdr, scramble(plain)};
                i_valid   <= 1'b1;
                sent++;
            end
        end
        @(posedge i_clock);
        i_valid <= 1'b0;
        @(negedge i_clock);
    endtask

    task automatic wb_access(input logic we, input logic [2:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        int n;
        n = 0;
        @(posedge i_clock);
        i_wb_cyc <= 1'b1;
        i_wb_stb <= 1'b1;
        i_wb_we  <= we;
        i_wb_adr <= adr;
        i_wb_dat <= wdat;
        do
        begin
            @(posedge i_clock);
            n++;
        end
        while (!o_wb_ack && n < 20);
        check_true(o_wb_ack, "no Wishbone ack within 20 cycles");
        rdat = o_wb_dat;
        if (!we)
            check_value("o_wb_dat", rdat, m_rdata);
        i_wb_cyc <= 1'b0;
        i_wb_stb <= 1'b0;
        @(negedge i_clock);
    endtask

    // model steps on each edge from the values sampled there
    always @(posedge i_clock)
    begin
        logic bad;
        logic good_hdr;
        logic hb_out;
        logic req;
        int   b_next;
        if (i_reset)
        begin
            {m_lock, m_sh_err, m_bh, m_hb_d, m_bypass, m_ack, m_valid, m_exp_ok} = '0;
            {m_good, m_win, m_inv, m_bw, m_bc, m_err_cnt, m_hb_cnt, m_blocks} = '0;
            m_en    = 1'b1;
            m_limit = 16;
        end
        else
        begin
            good_hdr = (i_block[65:64] == 2'b01) || (i_block[65:64] == 2'b10);
            bad      = i_valid && !good_hdr;
            hb_out   = m_bh & m_lock;
            req      = i_wb_cyc && i_wb_stb && !m_ack;
            if (req && !i_wb_we)
            begin
                case (i_wb_adr)
                    3'd0:    m_rdata = {30'd0, m_bypass, m_en};
                    3'd1:    m_rdata = 32'(m_limit);
                    3'd2:    m_rdata = {30'd0, hb_out, m_lock};
                    3'd3:    m_rdata = 32'(m_err_cnt);
                    3'd4:    m_rdata = 32'(m_hb_cnt);
                    default: m_rdata = '0;
                endcase
            end
            if (req && !i_wb_we && i_wb_adr == 3'd3)
                m_err_cnt = int'(m_sh_err);
            else if (m_sh_err && m_err_cnt != 16'hffff)
                m_err_cnt++;
            if (req && !i_wb_we && i_wb_adr == 3'd4)
                m_hb_cnt = int'(hb_out && !m_hb_d);
            else if (hb_out && !m_hb_d && m_hb_cnt != 16'hffff)
                m_hb_cnt++;
            m_hb_d = hb_out;
            // BER window, held while unlocked
            if (!m_lock)
            begin
                m_bw = 0;
                m_bc = 0;
                m_bh = 1'b0;
            end
            else
            begin
                b_next = (m_sh_err && m_bc < 16) ? m_bc + 1 : m_bc;
                if (i_valid && m_bw == 255)
                begin
                    m_bw = 0;
                    m_bc = 0;
                    m_bh = (b_next >= 16);
                end
                else
                begin
                    m_bw = i_valid ? m_bw + 1 : m_bw;
                    m_bc = b_next;
                    m_bh = m_bh || (b_next >= 16);
                end
            end
            // lock hunting and the 1024-block validation window
            if (!m_en)
            begin
                {m_lock, m_sh_err} = '0;
                {m_good, m_win, m_inv} = '0;
            end
            else
            begin
                m_sh_err = bad;
                if (i_valid && !m_lock)
                begin
                    m_good = good_hdr ? m_good + 1 : 0;
                    if (m_good == 64)
                    begin
                        m_lock = 1'b1;
                        {m_good, m_win, m_inv} = '0;
                    end
                end
                else if (i_valid && bad && m_inv + 1 >= m_limit)
                begin
                    m_lock = 1'b0;
                    {m_win, m_inv} = '0;
                end
                else if (i_valid)
                begin
                    m_inv = (m_win == 1023) ? 0 : m_inv + int'(bad);
                    m_win = (m_win == 1023) ? 0 : m_win + 1;
                end
            end
            m_valid = i_valid;
            if (i_valid)
            begin
                m_blocks++;
                m_exp    = {i_block[65:64], m_bypass ? i_block[63:0] : cur_plain};
                m_exp_ok = m_blocks >= 2;
            end
            if (req && i_wb_we && i_wb_adr == 3'd0)
            begin
                m_en     = i_wb_dat[0];
                m_bypass = i_wb_dat[1];
            end
            if (req && i_wb_we && i_wb_adr == 3'd1)
                m_limit = int'(i_wb_dat[7:0]);
            m_ack = req;
        end
    end

    always @(negedge i_clock)
    begin
        if (!i_reset)
        begin
            check_value("o_valid", o_valid, m_valid);
            check_value("o_block_lock", o_block_lock, m_lock);
            check_value("o_hi_ber", o_hi_ber, m_bh & m_lock);
            check_value("o_wb_ack", o_wb_ack, m_ack);
            if (o_valid && m_exp_ok)
                check_value("o_block", o_block, m_exp);
        end
    end

    always @(posedge i_clock)
    begin
        cycles++;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial
    begin
        logic [31:0] rd;
        int          n;
        i_reset   = 1'b1;
        i_valid   = 1'b0;
        i_block   = '0;
        cur_plain = '0;
        i_wb_cyc  = 1'b0;
        i_wb_stb  = 1'b0;
        i_wb_we   = 1'b0;
        i_wb_adr  = '0;
        i_wb_dat  = '0;
        repeat (3) @(posedge i_clock);
        i_reset <= 1'b0;

        // acquire lock, then check data plain and in bypass
        run_blocks(64, 0);
        check_true(o_block_lock, "no lock after 64 clean blocks");
        run_blocks(200, 0);
        wb_access(1'b1, 3'd0, 32'h3, rd);
        run_blocks(100, 0);
        wb_access(1'b1, 3'd0, 32'h1, rd);

        // lock loss at a limit of four
        wb_access(1'b1, 3'd1, 32'd4, rd);
        run_blocks(300, 3);
        check_true(o_block_lock, "lock lost with fewer than four bad headers");
        n = 0;
        while (m_lock && n < 8)
        begin
            run_blocks(1, 1);
            n++;
        end
        check_true(!o_block_lock, "lock held after four bad headers in a window");
        run_blocks(64, 0);
        check_true(o_block_lock, "lock not regained after 64 clean blocks");

        // high BER from a fresh lock so the window starts at a known block
        wb_access(1'b1, 3'd1, 32'd255, rd);
        wb_access(1'b1, 3'd0, 32'h0, rd);
        wb_access(1'b1, 3'd0, 32'h1, rd);
        run_blocks(64, 0);
        run_blocks(200, 16);
        run_blocks(30, 0);
        check_true(o_hi_ber, "hi_ber not raised by 16 bad headers in a window");
        run_blocks(600, 0);
        check_true(!o_hi_ber, "hi_ber not cleared after a clean window");

        // registers
        wb_access(1'b0, 3'd3, 32'd0, rd);
        check_true(rd != 0, "error counter read zero after bad headers");
        wb_access(1'b0, 3'd3, 32'd0, rd);
        check_value("err_count", rd, 0);
        wb_access(1'b0, 3'd4, 32'd0, rd);
        check_true(rd != 0, "hi_ber counter read zero after hi_ber");
        wb_access(1'b0, 3'd4, 32'd0, rd);
        check_value("hi_ber_count", rd, 0);
        wb_access(1'b1, 3'd0, 32'h3, rd);
        wb_access(1'b0, 3'd0, 32'd0, rd);
        check_value("ctrl", rd, 32'h3);
        wb_access(1'b1, 3'd1, 32'h5a, rd);
        wb_access(1'b0, 3'd1, 32'd0, rd);
        check_value("sh_limit", rd, 32'h5a);
        wb_access(1'b0, 3'd6, 32'd0, rd);
        check_value("unmapped", rd, 0);
        wb_access(1'b0, 3'd2, 32'd0, rd);

        repeat (5) @(posedge i_clock);
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- rx_pcs.f
+incdir+include
src/rx_pcs_pkg.sv
src/rx_regs_pkg.sv
src/block_sync.sv
src/ber_monitor.sv
src/descrambler.sv
src/rx_status_regs.sv
src/rx_pcs_top.sv
bench/rx_pcs_sva.sv
bench/rx_pcs_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rx_pcs_tb
FILELIST  ?= rx_pcs.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, fail if the log reports failure"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o sim
	$(BUILD_DIR)/sim 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
